// File: flist.f
gzip_pkg.sv
bit_field_if.sv
input_word_fifo.sv
crc32_engine.sv
stored_block_ctrl.sv
bit_packer.sv
gzip_stored_top.sv
tb_clock_gen.sv
tb_gzip_stored.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_gzip_stored
RTL_TOP   ?= gzip_stored_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_gzip_stored.sv
// ================================================
// Directed tests for the stored-block GZIP encoder. A byte model
// built from the format rules gives the expected output words
// ================================================
`timescale 1ns/1ns

module tb_gzip_stored;
	import gzip_pkg::*;

	localparam int TOTAL_WORDS  = 27; // Header and data words sent over all five tests
	localparam int WATCHDOG_CYC = 200 * TOTAL_WORDS + 2000;

	logic   clk;
	logic   por_n;
	logic   test_rst_n;
	logic   rst_n;
	logic   in_valid;
	word_t  in_data;
	logic   in_full;
	logic   out_valid;
	logic   out_last;
	word_t  out_data;
	word_t  crc_value;
	word_t  isize;
	logic   done;

	word_t  got_words[$];   // Output words as they leave the DUT
	logic   got_last[$];    // out_last next to each of them
	logic   last_seen;
	byte_t  payload[$];     // Data bytes of the block being sent
	byte_t  exp_bytes[$];   // Expected byte stream, trailer added at the end
	word_t  crc_model;      // Running CRC before the final complement
	word_t  isize_model;
	integer seed = 22;
	int     value_errors = 0;
	int     other_errors = 0;

	assign rst_n = por_n && test_rst_n; // Power-on reset or a reset from a test

	tb_clock_gen u_tb_clock_gen (
		.clk   (clk),
		.rst_n (por_n)
	);

	gzip_stored_top u_gzip_stored_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_full   (in_full),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_data  (out_data),
		.crc_value (crc_value),
		.isize     (isize),
		.done      (done)
	);

	// Outputs change on the rising edge and are read half a period later
	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			got_words.push_back(out_data);
			got_last.push_back(out_last);
			if (out_last) last_seen = 1'b1;
		end
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
		$display("Testbench failed");
		$finish;
	end

	// ================================================
	// Compare tasks and the reference model
	// ================================================
	task automatic check_word(input string name, input word_t exp, input word_t got);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s expected %08h, got %08h", $time, name, exp, got);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, got);
			value_errors++;
		end
	endtask

	// Bit-serial reflected CRC-32 that takes each byte LSB first
	function automatic word_t crc_add_byte(input word_t crc, input byte_t data);
		word_t c;
		logic  fb;
		c = crc;
		for (int k = 0; k < 8; k++) begin
			fb = c[0] ^ data[k];
			c  = {1'b0, c[31:1]};
			if (fb) c = c ^ 32'hEDB8_8320;
		end
		return c;
	endfunction

	task automatic clear_model();
		exp_bytes.delete();
		crc_model   = 32'hFFFF_FFFF; // All ones before the first byte
		isize_model = '0;
	endtask

	task automatic append_block_to_model(input logic bfinal);
		logic [15:0] len;
		len = 16'(payload.size());
		exp_bytes.push_back({7'b0, bfinal}); // BTYPE 00 and padding are all zero
		exp_bytes.push_back(len[7:0]);
		exp_bytes.push_back(len[15:8]);
		exp_bytes.push_back(~len[7:0]);      // NLEN follows LEN
		exp_bytes.push_back(~len[15:8]);
		foreach (payload[i]) begin
			exp_bytes.push_back(payload[i]);
			crc_model = crc_add_byte(crc_model, payload[i]);
		end
		isize_model = isize_model + 32'(len);
	endtask

	// ================================================
	// Stimulus
	// ================================================
	task automatic write_word(input word_t w);
		@(negedge clk);
		while (in_full) begin
			in_valid = 1'b0; // Hold back until the FIFO has room
			@(negedge clk);
		end
		in_valid = 1'b1;
		in_data  = w;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	task automatic make_payload(input int len);
		payload.delete();
		for (int i = 0; i < len; i++) begin
			payload.push_back(byte_t'($random(seed)));
		end
	endtask

	// Sends the header word and then the data words lowest byte first with gaps up to max_gap
	task automatic send_block(input logic bfinal, input int max_gap);
		stored_hdr_u hdr;
		word_t       w;
		int          len;
		len            = payload.size();
		hdr.raw        = '0;
		hdr.fld.bfinal = bfinal;
		hdr.fld.len    = 16'(len);
		write_word(hdr.raw);
		for (int i = 0; i < (len + 3) / 4; i++) begin
			w = 32'hEEEE_EEEE; // Bytes past LEN must never show up
			for (int b = 0; b < 4; b++) begin
				if (4 * i + b < len) w[8*b +: 8] = payload[4*i + b];
			end
			write_word(w);
			if (max_gap > 0) idle($unsigned($random(seed)) % (max_gap + 1));
		end
		idle(1);
	endtask

	task automatic pulse_reset(input int cycles);
		@(negedge clk);
		test_rst_n = 1'b0;
		in_valid   = 1'b0;
		got_words.delete();
		got_last.delete();
		last_seen = 1'b0;
		repeat (cycles) @(negedge clk);
		test_rst_n = 1'b1;
	endtask

	// Adds the trailer to the model, waits for out_last and checks everything
	task automatic finish_and_check(input string test_name);
		word_t crc_final;
		word_t exp_words[$];
		word_t w;
		int    cycles;
		crc_final = ~crc_model;
		for (int b = 0; b < 4; b++) exp_bytes.push_back(crc_final[8*b +: 8]);
		for (int b = 0; b < 4; b++) exp_bytes.push_back(isize_model[8*b +: 8]);
		for (int i = 0; i < exp_bytes.size(); i += 4) begin
			w = '0; // Tail of the last word is zero padded
			for (int b = 0; b < 4; b++) begin
				if (i + b < exp_bytes.size()) w[8*b +: 8] = exp_bytes[i + b];
			end
			exp_words.push_back(w);
		end
		cycles = 0;
		while (!last_seen && cycles < 1000) begin
			@(negedge clk);
			cycles++;
		end
		@(negedge clk);
		if (!last_seen) begin
			$display("%s: timed out waiting for out_last", test_name);
			other_errors++;
		end
		if (got_words.size() != exp_words.size()) begin
			$display("%s: expected %0d output words but collected %0d",
				test_name, exp_words.size(), got_words.size());
			other_errors++;
		end
		for (int i = 0; i < exp_words.size() && i < got_words.size(); i++) begin
			check_word($sformatf("out_data[%0d]", i), exp_words[i], got_words[i]);
			check_bit($sformatf("out_last[%0d]", i), logic'(i == exp_words.size() - 1),
				got_last[i]);
		end
		check_bit("done", 1'b1, done);
		check_word("crc_value", crc_final, crc_value);
		check_word("isize", isize_model, isize);
		$display("%s finished at %0t ns", test_name, $time);
	endtask

	// ================================================
	// Directed tests
	// ================================================
	task automatic single_final_block();
		pulse_reset(2);
		clear_model();
		make_payload(4);
		send_block(1'b1, 0);
		append_block_to_model(1'b1);
		finish_and_check("single final block");
	endtask

	task automatic partial_last_word();
		pulse_reset(2);
		clear_model();
		make_payload(5); // Three filler bytes in the second data word
		send_block(1'b1, 0);
		append_block_to_model(1'b1);
		finish_and_check("partial last word");
	endtask

	task automatic two_blocks();
		pulse_reset(2);
		clear_model();
		make_payload(3);
		send_block(1'b0, 0);
		append_block_to_model(1'b0);
		make_payload(6);
		send_block(1'b1, 0);
		append_block_to_model(1'b1);
		finish_and_check("two blocks");
	endtask

	task automatic input_gaps();
		pulse_reset(2);
		clear_model();
		make_payload(37);
		send_block(1'b1, 9); // Gaps over 3 cycles starve the controller mid-block
		append_block_to_model(1'b1);
		finish_and_check("gaps in the input");
	endtask

	task automatic reset_mid_stream();
		pulse_reset(2);
		make_payload(12);
		send_block(1'b1, 0);
		// Six of the twelve bytes are out and an output word is due on the next edge
		repeat (6) @(negedge clk);
		test_rst_n = 1'b0;
		@(negedge clk);
		check_bit("out_valid", 1'b0, out_valid);
		check_bit("done", 1'b0, done);
		check_bit("in_full", 1'b0, in_full);
		check_word("crc_value", '0, crc_value);
		check_word("isize", '0, isize);
		got_words.delete();
		got_last.delete();
		last_seen = 1'b0;
		@(negedge clk);
		test_rst_n = 1'b1;
		clear_model();
		make_payload(2);
		send_block(1'b1, 0);
		append_block_to_model(1'b1);
		finish_and_check("reset mid-stream");
	endtask

	initial begin
		test_rst_n = 1'b1;
		in_valid   = 1'b0;
		in_data    = '0;
		last_seen  = 1'b0;
		@(posedge por_n);
		single_final_block();
		partial_last_word();
		two_blocks();
		input_gaps();
		reset_mid_stream();
		$display("Error counts: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: tb_clock_gen.sv
// ================================================
// Testbench clock of 100 ns and a power-on reset held for 8 cycles
// ================================================
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // Half of the 100 ns period
	end

	// Reset lets go on a falling edge, like every other testbench input
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// File: gzip_stored_top.sv
// ================================================
// Stored-block Deflate encoder with GZIP trailer. Write words on
// in_valid, collect packed output words until out_last
// ================================================
`timescale 1ns/1ns

module gzip_stored_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	input  gzip_pkg::word_t in_data,
	output logic            in_full,   // Words sent while this is high are dropped
	output logic            out_valid,
	output logic            out_last,
	output gzip_pkg::word_t out_data,
	output gzip_pkg::word_t crc_value,
	output gzip_pkg::word_t isize,
	output logic            done
);
	import gzip_pkg::*;

	word_t fifo_data;
	logic  fifo_empty;
	logic  fifo_rd;
	logic  crc_byte_valid;
	byte_t crc_byte;

	bit_field_if field_bus ();

	// Input buffering
	input_word_fifo u_input_word_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (in_valid),
		.wr_data (in_data),
		.rd      (fifo_rd),
		.rd_data (fifo_data),
		.empty   (fifo_empty),
		.full    (in_full)
	);

	stored_block_ctrl u_stored_block_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.fifo_empty     (fifo_empty),
		.fifo_data      (fifo_data),
		.crc_value      (crc_value),
		.fifo_rd        (fifo_rd),
		.crc_byte_valid (crc_byte_valid),
		.crc_byte       (crc_byte),
		.isize          (isize),
		.done           (done),
		.field          (field_bus.source)
	);

	crc32_engine u_crc32_engine (
		.clk            (clk),
		.rst_n          (rst_n),
		.crc_byte_valid (crc_byte_valid),
		.crc_byte       (crc_byte),
		.crc_value      (crc_value)   // Also fed back for the trailer field
	);

	bit_packer u_bit_packer (
		.clk       (clk),
		.rst_n     (rst_n),
		.field     (field_bus.sink),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_data  (out_data)
	);

endmodule

// File: bit_packer.sv
// ================================================
// Packs bit fields LSB first into 32-bit output words.
// A last field flushes what is left, padded with zeros
// ================================================
`timescale 1ns/1ns

module bit_packer (
	input  logic            clk,
	input  logic            rst_n,
	bit_field_if.sink       field,
	output logic            out_valid,
	output logic            out_last,
	output gzip_pkg::word_t out_data
);
	import gzip_pkg::*;

	logic [2*WORD_W-1:0]     acc;        // Bits above fill are kept at zero
	logic [2*WORD_W-1:0]     acc_next;
	logic [2*WORD_W-1:0]     field_bits; // Field data with unused bits cleared
	logic [FIELD_SIZE_W-1:0] fill;       // Valid bits in acc, below 32 between fields
	logic [FIELD_SIZE_W-1:0] fill_next;
	logic                    word_ready; // A full word is available
	logic                    drain;      // One leftover word after the last field

	// Append the incoming field right above the bits already held
	always_comb begin
		field_bits = {{WORD_W{1'b0}}, field.data} & ~({(2*WORD_W){1'b1}} << field.size);
		acc_next   = acc;
		fill_next  = fill;
		if (field.valid) begin
			acc_next  = acc | (field_bits << fill);
			fill_next = fill + field.size; // At most 31 + 32, so no overflow
		end
	end

	assign word_ready = (fill_next >= FIELD_SIZE_W'(WORD_W));

	// ================================================
	// Word emission and flushing
	// ================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc       <= '0;
			fill      <= '0;
			drain     <= 1'b0;
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
			if (drain) begin
				out_valid <= 1'b1; // Leftover bits, already zero padded
				out_last  <= 1'b1;
				acc       <= '0;
				fill      <= '0;
				drain     <= 1'b0;
			end else if (field.valid && field.last) begin
				out_valid <= 1'b1;
				if (fill_next > FIELD_SIZE_W'(WORD_W)) begin
					acc   <= acc_next >> WORD_W;
					fill  <= fill_next - FIELD_SIZE_W'(WORD_W);
					drain <= 1'b1; // Another word follows next cycle
				end else begin
					out_last <= 1'b1; // Everything fits in this word
					acc      <= '0;
					fill     <= '0;
				end
			end else if (word_ready) begin
				out_valid <= 1'b1;
				acc       <= acc_next >> WORD_W;
				fill      <= fill_next - FIELD_SIZE_W'(WORD_W);
			end else begin
				acc  <= acc_next;
				fill <= fill_next;
			end
		end
	end

	// Low word of the accumulator, which no field changes while draining
	always_ff @(posedge clk) begin
		out_data <= acc_next[WORD_W-1:0];
	end

endmodule

// File: stored_block_ctrl.sv
// ================================================
// Walks header, LEN/NLEN, data bytes and the trailer of each
// stored block, and hands every piece to the packer as a bit field
// ================================================
`timescale 1ns/1ns

module stored_block_ctrl (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            fifo_empty,
	input  gzip_pkg::word_t fifo_data,
	input  gzip_pkg::word_t crc_value,
	output logic            fifo_rd,
	output logic            crc_byte_valid,
	output gzip_pkg::byte_t crc_byte,
	output gzip_pkg::word_t isize,
	output logic            done,
	bit_field_if.source     field
);
	import gzip_pkg::*;

	blk_state_e  state;
	blk_state_e  next_state;
	stored_hdr_u hdr;        // Head word of the FIFO read as a block header
	word_t       cur_word;   // Data word the bytes are taken from
	word_t       src_word;   // Either the held word or the FIFO head
	logic        have_word;  // cur_word still has bytes for this block
	logic [1:0]  byte_idx;   // Byte lane inside the current word, lowest first
	logic [15:0] remaining;  // Bytes still to send in this block
	logic [15:0] len_q;
	logic        bfinal_q;
	logic        byte_go;    // A data byte goes out this cycle
	logic        last_byte;  // That byte closes the block

	assign hdr.raw   = fifo_data;
	assign src_word  = have_word ? cur_word : fifo_data; // Byte 0 can come straight from the FIFO
	assign byte_go   = (state == LOAD_BYTE) && (have_word || !fifo_empty);
	assign last_byte = (remaining == 16'd1);
	assign crc_byte  = src_word[{byte_idx, 3'b000} +: 8];
	assign done      = (state == DONE);

	// ================================================
	// Next state, FIFO pops and the field for this cycle
	// ================================================
	always_comb begin
		next_state     = state;
		fifo_rd        = 1'b0;
		crc_byte_valid = 1'b0;
		field.valid    = 1'b0;
		field.last     = 1'b0;
		field.size     = '0;
		field.data     = '0;
		case (state)
			IDLE: begin
				if (!fifo_empty) begin
					fifo_rd    = 1'b1; // Header word leaves the FIFO now
					next_state = HEADER;
				end
			end
			HEADER: begin
				// BFINAL in bit 0, BTYPE 00 in bits 2:1, zeros up to the byte boundary
				field.valid = 1'b1;
				field.size  = FIELD_SIZE_W'(8);
				field.data  = {{(WORD_W-1){1'b0}}, bfinal_q};
				next_state  = BLOCK_LEN;
			end
			BLOCK_LEN: begin
				field.valid = 1'b1;
				field.size  = FIELD_SIZE_W'(32);
				field.data  = {~len_q, len_q}; // LEN goes out first, then NLEN
				if (len_q != 16'd0) next_state = LOAD_BYTE;
				else if (bfinal_q)  next_state = CRC32; // Empty final block
				else                next_state = IDLE;
			end
			LOAD_BYTE: begin
				if (byte_go) begin
					fifo_rd        = !have_word; // Pop the word whose byte 0 goes out now
					crc_byte_valid = 1'b1;
					field.valid    = 1'b1;
					field.size     = FIELD_SIZE_W'(8);
					field.data     = {{(WORD_W-8){1'b0}}, crc_byte};
					if (last_byte) next_state = bfinal_q ? CRC32 : IDLE;
				end
			end
			CRC32: begin
				// Last CRC update landed on the previous edge
				field.valid = 1'b1;
				field.size  = FIELD_SIZE_W'(32);
				field.data  = crc_value;
				next_state  = ISIZE;
			end
			ISIZE: begin
				field.valid = 1'b1;
				field.last  = 1'b1; // Tells the packer to flush
				field.size  = FIELD_SIZE_W'(32);
				field.data  = isize;
				next_state  = DONE;
			end
			DONE:    next_state = DONE; // Only reset leaves this state
			default: next_state = IDLE;
		endcase
	end

	// ================================================
	// Control registers
	// ================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			have_word <= 1'b0;
			byte_idx  <= '0;
			remaining <= '0;
			len_q     <= '0;
			bfinal_q  <= 1'b0;
			isize     <= '0;
		end else begin
			state <= next_state;
			if (state == IDLE && !fifo_empty) begin
				len_q    <= hdr.fld.len;
				bfinal_q <= hdr.fld.bfinal;
				isize    <= isize + {16'd0, hdr.fld.len}; // Wraps modulo 2^32
			end
			if (state == BLOCK_LEN) begin
				remaining <= len_q;
				byte_idx  <= '0; // Data always starts in a fresh word
				have_word <= 1'b0;
			end
			if (byte_go) begin
				remaining <= remaining - 1'b1;
				byte_idx  <= last_byte ? 2'd0 : byte_idx + 1'b1;
				// The word is used up after byte 3 or at the end of the block
				have_word <= !(last_byte || byte_idx == 2'd3);
			end
		end
	end

	// Data word holder
	always_ff @(posedge clk) begin
		if (byte_go && !have_word) begin
			cur_word <= fifo_data;
		end
	end

endmodule

// File: crc32_engine.sv
// ================================================
// Byte-serial CRC-32 over the data bytes, as GZIP wants it.
// Strobe one byte per cycle, read the result a cycle later
// ================================================
`timescale 1ns/1ns

module crc32_engine (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            crc_byte_valid,
	input  gzip_pkg::byte_t crc_byte,
	output gzip_pkg::word_t crc_value
);
	import gzip_pkg::*;

	word_t crc_reg;  // Running remainder, starts at all ones
	word_t crc_next; // Remainder after folding in crc_byte

	// ================================================
	// Eight reflected shift-and-xor steps, one per input bit
	// ================================================
	always_comb begin
		crc_next = crc_reg ^ {{(WORD_W-8){1'b0}}, crc_byte}; // LSB of the byte goes in first
		for (int i = 0; i < 8; i++) begin
			if (crc_next[0]) begin
				crc_next = (crc_next >> 1) ^ CRC_POLY; // Feedback tap set
			end else begin
				crc_next = crc_next >> 1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crc_reg <= CRC_INIT;
		end else if (crc_byte_valid) begin
			crc_reg <= crc_next;
		end
	end

	// Final complement, which also makes the value read zero after reset
	assign crc_value = crc_reg ^ CRC_INIT;

endmodule

// File: input_word_fifo.sv
// ================================================
// Small synchronous FIFO that buffers input words until the
// block controller pulls them. Head word is shown combinationally
// ================================================
`timescale 1ns/1ns

module input_word_fifo (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           wr,
	input  gzip_pkg::word_t wr_data,
	input  logic           rd,
	output gzip_pkg::word_t rd_data,
	output logic           empty,
	output logic           full
);
	import gzip_pkg::*;

	word_t                  mem [FIFO_DEPTH]; // Word storage
	logic [FIFO_ADDR_W-1:0] wr_ptr;
	logic [FIFO_ADDR_W-1:0] rd_ptr;
	logic [FIFO_ADDR_W:0]   count;            // One extra bit so a full FIFO can be told apart
	logic                   do_wr;
	logic                   do_rd;

	assign do_wr = wr && !full;  // A write into a full FIFO is simply lost
	assign do_rd = rd && !empty; // A read of an empty FIFO does nothing

	assign empty   = (count == '0);
	assign full    = (count == (FIFO_ADDR_W+1)'(FIFO_DEPTH));
	assign rd_data = mem[rd_ptr]; // Head word is valid whenever the FIFO holds data

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// Pointers wrap on their own because the depth is a power of two
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1; // Write only
				2'b01:   count <= count - 1'b1; // Read only
				default: count <= count;        // Both or neither leave the fill unchanged
			endcase
		end
	end

endmodule

// File: bit_field_if.sv
// ================================================
// One variable-size bit field per cycle, sent from the
// block controller to the bit packer without back-pressure
// ================================================
`timescale 1ns/1ns

interface bit_field_if;
	import gzip_pkg::*;

	logic                    valid; // Single-cycle strobe
	logic                    last;  // Final field of the whole stream
	logic [FIELD_SIZE_W-1:0] size;  // Number of valid bits, 1 to 32
	word_t                   data;  // Only the low size bits are meaningful

	// Controller side drives every signal
	modport source (
		output valid,
		output last,
		output size,
		output data
	);

	// Packer side only listens
	modport sink (
		input valid,
		input last,
		input size,
		input data
	);

endinterface

// File: gzip_pkg.sv
// ================================================
// Shared sizes, FSM states, header word view and CRC constants
// for the stored-block GZIP encoder. Import where needed
// ================================================

package gzip_pkg;

	// ================================================
	// Word and field sizes
	// ================================================
	localparam int WORD_W       = 32; // Input and output word width
	localparam int FIELD_SIZE_W = 6;  // Holds a field size of 0 to 32 bits
	localparam int FIFO_DEPTH   = 16; // Input FIFO entries
	localparam int FIFO_ADDR_W  = 4;  // Enough to address FIFO_DEPTH entries

	// ================================================
	// CRC-32 constants as used by GZIP
	// ================================================
	localparam logic [WORD_W-1:0] CRC_POLY = 32'hEDB8_8320; // Reflected form of 04C11DB7
	localparam logic [WORD_W-1:0] CRC_INIT = 32'hFFFF_FFFF; // Start value and final XOR mask

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [7:0]        byte_t;

	// Block controller FSM states
	typedef enum logic [2:0] {
		IDLE,      // Wait for a header word in the FIFO
		HEADER,    // BFINAL and BTYPE 00 padded to a byte
		BLOCK_LEN, // LEN in the low half, NLEN in the high half
		LOAD_BYTE, // Literal bytes, one per cycle
		CRC32,     // CRC over all data bytes
		ISIZE,     // Byte count, final field of the stream
		DONE       // Parked until reset
	} blk_state_e;

	// Header word, seen either as a plain word or as its fields
	// Bit 24 carries BFINAL and bits 15:0 carry LEN
	typedef union packed {
		word_t raw;
		struct packed {
			logic [6:0]  rsvd_hi;  // Unused
			logic        bfinal;   // Last block of the stream
			logic [7:0]  rsvd_mid; // Unused
			logic [15:0] len;      // Data bytes in this block
		} fld;
	} stored_hdr_u;

endpackage
